// File: build.f
+incdir+.
rv_pkg.sv
regFile.sv
decodeStage.sv
decodeExecuteReg.sv
executeStage.sv
hazardUnit.sv
coreSliceTop.sv
coreSlice_asserts.sv
coreSliceTb.sv

// File: coreSliceTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module coreSliceTb;

    typedef struct packed {
        logic                redir;
        logic [`RV_XLEN-1:0] redirPc;
        rv_pkg::retireRec    rec;
    } expectRec;

    logic                clk = 1'b0;
    logic                rstN;
    logic                instrValid;
    rv_pkg::instrWord    instr;
    logic [`RV_XLEN-1:0] instrPc;
    rv_pkg::retireRec    retire;
    logic                redirectValid;
    logic [`RV_XLEN-1:0] redirectPc;

    logic [`RV_XLEN-1:0] modelRegs [0:`RV_REG_COUNT-1];
    logic [`RV_XLEN-1:0] modelPc;
    logic [31:0]         seed = 32'hb2cc;
    expectRec            pipeA;
    expectRec            pipeB;
    int                  errors = 0;
    int                  errMark = 0;
    int                  checks = 0;
    int                  tests = 0;

    coreSliceTop coreSliceTop_i (
        .clk           (clk),
        .rstN          (rstN),
        .instrValid    (instrValid),
        .instr         (instr),
        .instrPc       (instrPc),
        .retire        (retire),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc)
    );

    always #5 clk = ~clk;

    initial begin
        #20000;
        $display("timeout: testbench did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [`RV_XLEN-1:0] aluRef(input logic [2:0] f3, input logic alt,
                                                   input logic [`RV_XLEN-1:0] a,
                                                   input logic [`RV_XLEN-1:0] b);
        logic [`RV_XLEN-1:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // ISA reference for one instruction at pc
    function automatic expectRec predict(input logic [31:0] w, input logic [31:0] pc);
        expectRec            e;
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic [`RV_XLEN-1:0] immI;
        logic [2:0]          f3;
        logic                known;
        a              = modelRegs[w[19:15]];
        b              = modelRegs[w[24:20]];
        immI           = {{20{w[31]}}, w[31:20]};
        f3             = w[14:12];
        e              = '0;
        known          = 1'b1;
        e.rec.regWrite = 1'b1;
        case (w[6:0])
            7'b0110011: begin
                known = (w[31:25] == 7'h00) ||
                        ((w[31:25] == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
                e.rec.data = aluRef(f3, w[30], a, b);
            end
            7'b0010011: begin
                if (f3 == 3'd1) begin
                    known = (w[31:25] == 7'h00);
                end
                if (f3 == 3'd5) begin
                    known = (w[31:25] == 7'h00) || (w[31:25] == 7'h20);
                end
                e.rec.data = aluRef(f3, (f3 == 3'd5) && w[30], a, immI);
            end
            7'b0110111: e.rec.data = {w[31:12], 12'd0};
            7'b1101111: begin
                e.rec.data = pc + 32'd4;
                e.redir    = 1'b1;
                e.redirPc  = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b1100111: begin
                known      = (f3 == 3'd0);
                e.rec.data = pc + 32'd4;
                e.redir    = 1'b1;
                e.redirPc  = (a + immI) & ~32'd1;
            end
            7'b1100011: begin
                e.rec.regWrite = 1'b0;
                case (f3)
                    3'd0: e.redir = (a == b);
                    3'd1: e.redir = (a != b);
                    3'd4: e.redir = $signed(a) < $signed(b);
                    3'd5: e.redir = $signed(a) >= $signed(b);
                    default: known = 1'b0;
                endcase
                e.redirPc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            default: known = 1'b0;
        endcase
        e.rec.valid    = 1'b1;
        e.rec.rd       = w[11:7];
        e.rec.pc       = pc;
        e.rec.regWrite = e.rec.regWrite && (w[11:7] != 5'd0);
        if (!known) begin
            e = '0;
        end
        return e;
    endfunction

    function automatic int failTotal();
        return errors + coreSliceTop_i.coreSliceAsserts_i.failCount;
    endfunction

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        errors++;
    endtask

    // Retire shows the instruction from two steps back, redirect the one from one step back
    task automatic checkOutputs();
        checks++;
        assert (retire.valid === pipeB.rec.valid)
            else mismatch("retire.valid", pipeB.rec.valid, retire.valid);
        if (pipeB.rec.valid) begin
            assert (retire.rd === pipeB.rec.rd)
                else mismatch("retire.rd", pipeB.rec.rd, retire.rd);
            assert (retire.regWrite === pipeB.rec.regWrite)
                else mismatch("retire.regWrite", pipeB.rec.regWrite, retire.regWrite);
            assert (retire.pc === pipeB.rec.pc)
                else mismatch("retire.pc", pipeB.rec.pc, retire.pc);
            if (pipeB.rec.regWrite) begin
                assert (retire.data === pipeB.rec.data)
                    else mismatch("retire.data", pipeB.rec.data, retire.data);
            end
        end
        assert (redirectValid === pipeA.redir)
            else mismatch("redirectValid", pipeA.redir, redirectValid);
        if (pipeA.redir) begin
            assert (redirectPc === pipeA.redirPc)
                else mismatch("redirectPc", pipeA.redirPc, redirectPc);
        end
    endtask

    task automatic issue(input logic [31:0] word, input logic valid);
        expectRec e;
        @(negedge clk);
        checkOutputs();
        e = '0;
        // Slot behind a taken redirect is squashed
        if (valid && !pipeA.redir) begin
            e = predict(word, modelPc);
        end
        instr      = word;
        instrValid = valid;
        instrPc    = modelPc;
        if (pipeA.redir) begin
            modelPc = pipeA.redirPc;
        end else if (valid) begin
            modelPc = modelPc + 32'd4;
        end
        if (e.rec.regWrite) begin
            modelRegs[e.rec.rd] = e.rec.data;
        end
        pipeB = pipeA;
        pipeA = e;
    endtask

    task automatic finishTest(input string name);
        int waitCount;
        waitCount = 0;
        while ((pipeA.rec.valid || pipeB.rec.valid || pipeA.redir) && (waitCount < 8)) begin
            issue('0, 1'b0);
            waitCount++;
        end
        if (waitCount >= 8) begin
            $display("timeout: pipeline did not drain after test %s", name);
            errors++;
        end
        $display("test %s: %0d failures", name, failTotal() - errMark);
        errMark = failTotal();
        tests++;
    endtask

    task automatic branchThenFiller(input logic [2:0] f3, input logic [4:0] rsA,
                                    input logic [4:0] rsB, input logic [12:0] offset);
        issue(encB(offset, rsB, rsA, f3), 1'b1);
        issue(encI(12'd1, 5'd4, 3'd0, 5'd4, 7'b0010011), 1'b1);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [6:0]  f7;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        instrPc    = `RV_RESET_PC;
        modelPc    = `RV_RESET_PC;
        pipeA      = '0;
        pipeB      = '0;
        for (int k = 0; k < `RV_REG_COUNT; k++) begin
            modelRegs[k] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        repeat (4) issue('0, 1'b0);
        finishTest("reset");

        // Seed x1..x7 with lui and addi
        for (int k = 1; k < 8; k++) begin
            r = nextRand();
            issue({r[31:12], 5'(k), 7'b0110111}, 1'b1);
            issue(encI(r[11:0], 5'(k), 3'd0, 5'(k), 7'b0010011), 1'b1);
        end
        for (int n = 0; n < 40; n++) begin
            r   = nextRand();
            r2  = nextRand();
            f3  = r[19:17];
            rd  = {2'b00, r[10:8]};
            f7  = {1'b0, r[20] && ((f3 == 3'd0) || (f3 == 3'd5)), 5'd0};
            imm = r2[11:0];
            if (f3 == 3'd1) begin
                imm[11:5] = 7'h00;
            end
            if (f3 == 3'd5) begin
                imm[11:5] = f7;
            end
            case (r[22:21])
                2'd0: issue(encR(f7, {2'b00, r[16:14]}, {2'b00, r[13:11]}, f3, rd), 1'b1);
                2'd3: issue({r2[31:12], rd, 7'b0110111}, 1'b1);
                default: issue(encI(imm, {2'b00, r[13:11]}, f3, rd, 7'b0010011), 1'b1);
            endcase
        end
        issue(encI(12'd77, 5'd1, 3'd0, 5'd0, 7'b0010011), 1'b1);
        issue(encR(7'h00, 5'd0, 5'd0, 3'd0, 5'd5), 1'b1);
        finishTest("alu");

        for (int gap = 0; gap < 2; gap++) begin
            for (int mode = 0; mode < 3; mode++) begin
                r = nextRand();
                issue(encI(r[11:0], 5'd2, 3'd0, 5'd1, 7'b0010011), 1'b1);
                if (gap == 1) begin
                    issue(encI(12'd7, 5'd6, 3'd4, 5'd7, 7'b0010011), 1'b1);
                end
                case (mode)
                    0: issue(encR(7'h00, 5'd4, 5'd1, 3'd0, 5'd3), 1'b1);
                    1: issue(encR(7'h20, 5'd1, 5'd4, 3'd0, 5'd3), 1'b1);
                    default: issue(encR(7'h00, 5'd1, 5'd1, 3'd0, 5'd3), 1'b1);
                endcase
            end
        end
        finishTest("forwarding");

        // x1 = 5, x2 = 5, x3 = -3
        issue(encI(12'd5, 5'd0, 3'd0, 5'd1, 7'b0010011), 1'b1);
        issue(encI(12'd5, 5'd0, 3'd0, 5'd2, 7'b0010011), 1'b1);
        issue(encI(12'hffd, 5'd0, 3'd0, 5'd3, 7'b0010011), 1'b1);
        branchThenFiller(3'd0, 5'd1, 5'd2, 13'd16);
        branchThenFiller(3'd0, 5'd1, 5'd3, 13'd8);
        branchThenFiller(3'd1, 5'd1, 5'd3, 13'h1ff4);
        branchThenFiller(3'd1, 5'd1, 5'd2, 13'd12);
        branchThenFiller(3'd4, 5'd3, 5'd1, 13'd20);
        branchThenFiller(3'd4, 5'd1, 5'd3, 13'd8);
        branchThenFiller(3'd5, 5'd1, 5'd3, 13'h1ff8);
        branchThenFiller(3'd5, 5'd3, 5'd1, 13'd8);
        finishTest("branch");

        issue(encJ(21'd24, 5'd5), 1'b1);
        issue(encI(12'd1, 5'd4, 3'd0, 5'd4, 7'b0010011), 1'b1);
        // Sum 7 is odd, target drops bit 0
        issue(encI(12'd2, 5'd1, 3'd0, 5'd6, 7'b1100111), 1'b1);
        issue(encI(12'd1, 5'd4, 3'd0, 5'd4, 7'b0010011), 1'b1);
        issue(encI(12'h040, 5'd2, 3'd0, 5'd7, 7'b1100111), 1'b1);
        issue(encI(12'd1, 5'd4, 3'd0, 5'd4, 7'b0010011), 1'b1);
        issue(encR(7'h00, 5'd6, 5'd5, 3'd0, 5'd8), 1'b1);
        finishTest("jump");

        issue(32'hffff_ffff, 1'b1);
        issue(encI(12'd1, 5'd1, 3'd0, 5'd1, 7'b0001011), 1'b1);
        issue(encI(12'd9, 5'd1, 3'd0, 5'd1, 7'b0010011), 1'b0);
        issue(encR(7'h00, 5'd0, 5'd1, 3'd0, 5'd9), 1'b1);
        issue(encR(7'h00, 5'd0, 5'd31, 3'd0, 5'd10), 1'b1);
        finishTest("bubble");

        $display("tests %0d, checks %0d, failures %0d", tests, checks, failTotal());
        if (failTotal() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: coreSliceTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module coreSliceTop (
    input  logic                clk,
    input  logic                rstN,
    input  logic                instrValid,
    input  rv_pkg::instrWord    instr,
    input  logic [`RV_XLEN-1:0] instrPc,
    output rv_pkg::retireRec    retire,
    output logic                redirectValid,
    output logic [`RV_XLEN-1:0] redirectPc
);

    rv_pkg::decodeBundle decBundle;
    rv_pkg::decodeBundle exBundle;
    logic                fwdA;
    logic                fwdB;
    logic                flush;
    logic                branchTaken;

    decodeStage decodeStage_i (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .instrPc    (instrPc),
        .wbRec      (retire),
        .decBundle  (decBundle)
    );

    decodeExecuteReg decodeExecuteReg_i (
        .clk       (clk),
        .rstN      (rstN),
        .flush     (flush),
        .decBundle (decBundle),
        .exBundle  (exBundle)
    );

    executeStage executeStage_i (
        .clk           (clk),
        .rstN          (rstN),
        .exBundle      (exBundle),
        .fwdA          (fwdA),
        .fwdB          (fwdB),
        .retire        (retire),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .branchTaken   (branchTaken)
    );

    hazardUnit hazardUnit_i (
        .exBundle    (exBundle),
        .retire      (retire),
        .branchTaken (branchTaken),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .flush       (flush)
    );

endmodule

`default_nettype wire

// File: coreSlice_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module coreSliceAsserts (
    input logic                clk,
    input logic                rstN,
    input rv_pkg::retireRec    retire,
    input logic                redirectValid,
    input logic [`RV_XLEN-1:0] redirectPc
);

    int   failCount;
    logic inReset;

    // Set once reset has been seen at an edge, so exBundle is cleared
    always_ff @(posedge clk) begin
        inReset <= !rstN;
    end

    noX0Write: assert property (@(posedge clk) disable iff (!rstN)
        !(retire.valid && retire.regWrite && (retire.rd == 5'd0)))
        else begin
            failCount++;
            $error("retire record writes x0");
        end

    evenTarget: assert property (@(posedge clk) disable iff (!rstN)
        redirectValid |-> !redirectPc[0])
        else begin
            failCount++;
            $error("redirect target is odd");
        end

    // Squashed slot reaches retire two edges later
    squashAfterRedirect: assert property (@(posedge clk) disable iff (!rstN)
        redirectValid |-> ##2 !retire.valid)
        else begin
            failCount++;
            $error("instruction after a redirect retired");
        end

    quietInReset: assert property (@(posedge clk)
        (!rstN && inReset) |-> !redirectValid)
        else begin
            failCount++;
            $error("redirect raised during reset");
        end

endmodule

bind coreSliceTop coreSliceAsserts coreSliceAsserts_i (
    .clk           (clk),
    .rstN          (rstN),
    .retire        (retire),
    .redirectValid (redirectValid),
    .redirectPc    (redirectPc)
);

`default_nettype wire

// File: decodeExecuteReg.sv
`timescale 1ns/1ps
`default_nettype none

module decodeExecuteReg (
    input  logic                clk,
    input  logic                rstN,
    input  logic                flush,
    input  rv_pkg::decodeBundle decBundle,
    output rv_pkg::decodeBundle exBundle
);

    // All-zero bubble has valid and regWrite clear
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            exBundle <= '0;
        end else begin
            exBundle <= decBundle;
        end
    end

endmodule

`default_nettype wire

// File: decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module decodeStage (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  rv_pkg::instrWord     instr,
    input  logic [`RV_XLEN-1:0]  instrPc,
    input  rv_pkg::retireRec     wbRec,
    output rv_pkg::decodeBundle  decBundle
);

    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpJalr   = 7'b1100111;
    localparam logic [6:0] OpBranch = 7'b1100011;

    logic [6:0]          opcode;
    logic [6:0]          funct7;
    logic [2:0]          funct3;
    logic [11:0]         imm12;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] immI;
    logic [`RV_XLEN-1:0] immB;
    logic [`RV_XLEN-1:0] immJ;
    logic [`RV_XLEN-1:0] immU;
    logic [`RV_XLEN-1:0] immExt;
    logic [`RV_XLEN-1:0] rdata1;
    logic [`RV_XLEN-1:0] rdata2;
    logic                wbWrites;
    logic                known;
    rv_pkg::ctrlBundle   ctrl;

    // funct3 plus the alternate bit picks the ALU operation
    function automatic rv_pkg::aluOp aluFor(input logic [2:0] f3, input logic alt);
        rv_pkg::aluOp op;
        case (f3)
            3'b000:  op = alt ? rv_pkg::aluSub : rv_pkg::aluAdd;
            3'b001:  op = rv_pkg::aluSll;
            3'b010:  op = rv_pkg::aluSlt;
            3'b011:  op = rv_pkg::aluSltu;
            3'b100:  op = rv_pkg::aluXor;
            3'b101:  op = alt ? rv_pkg::aluSra : rv_pkg::aluSrl;
            3'b110:  op = rv_pkg::aluOr;
            default: op = rv_pkg::aluAnd;
        endcase
        return op;
    endfunction

    assign opcode = instr.r.opcode;
    assign funct7 = instr.r.funct7;
    assign rs2    = instr.r.rs2;
    assign rd     = instr.r.rd;
    assign imm12  = instr.i.imm12;
    assign rs1    = instr.i.rs1;
    assign funct3 = instr.i.funct3;

    // Immediate formats rebuilt from the two views
    assign immI = {{20{imm12[11]}}, imm12};
    assign immB = {{20{funct7[6]}}, rd[0], funct7[5:0], rd[4:1], 1'b0};
    assign immJ = {{12{imm12[11]}}, rs1, funct3, imm12[0], imm12[10:1], 1'b0};
    assign immU = {imm12, rs1, funct3, 12'd0};

    always_comb begin
        ctrl   = '0;
        known  = 1'b0;
        immExt = immI;
        case (opcode)
            OpReg: begin
                known = (funct7 == 7'b0000000) ||
                        ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluFor(funct3, funct7[5]);
            end
            OpImm: begin
                // Shifts reuse funct7 as a qualifier
                if (funct3 == 3'b001) begin
                    known = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    known = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    known = 1'b1;
                end
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluFor(funct3, (funct3 == 3'b101) && funct7[5]);
            end
            OpLui: begin
                known          = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = rv_pkg::aluPassB;
                ctrl.isLui     = 1'b1;
                immExt         = immU;
            end
            OpJal: begin
                known           = 1'b1;
                ctrl.regWrite   = 1'b1;
                ctrl.jump       = 1'b1;
                ctrl.linkResult = 1'b1;
                immExt          = immJ;
            end
            OpJalr: begin
                known           = (funct3 == 3'b000);
                ctrl.regWrite   = 1'b1;
                ctrl.jump       = 1'b1;
                ctrl.jalr       = 1'b1;
                ctrl.linkResult = 1'b1;
            end
            OpBranch: begin
                // beq, bne, blt, bge only
                known           = (funct3 == 3'b000) || (funct3 == 3'b001) ||
                                  (funct3 == 3'b100) || (funct3 == 3'b101);
                ctrl.branch     = 1'b1;
                ctrl.branchCond = funct3;
                ctrl.aluOp      = rv_pkg::aluSub;
                immExt          = immB;
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    assign wbWrites = wbRec.valid && wbRec.regWrite && (wbRec.rd != 5'd0);

    regFile regFile_i (
        .clk    (clk),
        .rstN   (rstN),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .we     (wbWrites),
        .waddr  (wbRec.rd),
        .wdata  (wbRec.data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    always_comb begin
        decBundle.valid   = instrValid && known;
        decBundle.ctrl    = decBundle.valid ? ctrl : '0;
        // Bypass the retire record until its register write lands
        decBundle.rd1     = (wbWrites && (wbRec.rd == rs1)) ? wbRec.data : rdata1;
        decBundle.rd2     = (wbWrites && (wbRec.rd == rs2)) ? wbRec.data : rdata2;
        decBundle.pc      = instrPc;
        decBundle.pcPlus4 = instrPc + `RV_XLEN'd4;
        decBundle.immExt  = immExt;
        decBundle.rs1     = rs1;
        decBundle.rs2     = rs2;
        decBundle.rd      = rd;
    end

endmodule

`default_nettype wire

// File: executeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module executeStage (
    input  logic                 clk,
    input  logic                 rstN,
    input  rv_pkg::decodeBundle  exBundle,
    input  logic                 fwdA,
    input  logic                 fwdB,
    output rv_pkg::retireRec     retire,
    output logic                 redirectValid,
    output logic [`RV_XLEN-1:0]  redirectPc,
    output logic                 branchTaken
);

    logic [`RV_XLEN-1:0] opA;
    logic [`RV_XLEN-1:0] opBReg;
    logic [`RV_XLEN-1:0] opB;
    logic [`RV_XLEN-1:0] aluResult;
    logic [`RV_XLEN-1:0] pcTarget;
    logic [`RV_XLEN-1:0] jalrSum;
    logic [`RV_XLEN-1:0] resultData;
    logic                condTrue;
    rv_pkg::retireRec    nextRec;

    // Retire register holds the previous instruction's result
    assign opA    = fwdA ? retire.data : exBundle.rd1;
    assign opBReg = fwdB ? retire.data : exBundle.rd2;
    assign opB    = exBundle.ctrl.aluSrcImm ? exBundle.immExt : opBReg;

    always_comb begin
        case (exBundle.ctrl.aluOp)
            rv_pkg::aluAdd:   aluResult = opA + opB;
            rv_pkg::aluSub:   aluResult = opA - opB;
            rv_pkg::aluAnd:   aluResult = opA & opB;
            rv_pkg::aluOr:    aluResult = opA | opB;
            rv_pkg::aluXor:   aluResult = opA ^ opB;
            rv_pkg::aluSlt:   aluResult = {{(`RV_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            rv_pkg::aluSltu:  aluResult = {{(`RV_XLEN-1){1'b0}}, opA < opB};
            rv_pkg::aluSll:   aluResult = opA << opB[4:0];
            rv_pkg::aluSrl:   aluResult = opA >> opB[4:0];
            rv_pkg::aluSra:   aluResult = $signed(opA) >>> opB[4:0];
            rv_pkg::aluPassB: aluResult = opB;
            default:          aluResult = opA + opB;
        endcase
    end

    // Compare uses register operands, never the immediate
    always_comb begin
        case (exBundle.ctrl.branchCond)
            3'b000:  condTrue = (opA == opBReg);
            3'b001:  condTrue = (opA != opBReg);
            3'b100:  condTrue = $signed(opA) < $signed(opBReg);
            3'b101:  condTrue = $signed(opA) >= $signed(opBReg);
            default: condTrue = 1'b0;
        endcase
    end

    assign branchTaken = (exBundle.ctrl.branch && condTrue) || exBundle.ctrl.jump;

    assign pcTarget = exBundle.pc + exBundle.immExt;
    assign jalrSum  = opA + exBundle.immExt;

    assign redirectValid = exBundle.valid && branchTaken;
    assign redirectPc    = exBundle.ctrl.jalr ? {jalrSum[`RV_XLEN-1:1], 1'b0} : pcTarget;

    always_comb begin
        if (exBundle.ctrl.linkResult) begin
            resultData = exBundle.pcPlus4;
        end else if (exBundle.ctrl.isLui) begin
            resultData = exBundle.immExt;
        end else begin
            resultData = aluResult;
        end
    end

    always_comb begin
        nextRec.valid    = exBundle.valid;
        nextRec.regWrite = exBundle.valid && exBundle.ctrl.regWrite && (exBundle.rd != 5'd0);
        nextRec.rd       = exBundle.rd;
        nextRec.data     = resultData;
        nextRec.pc       = exBundle.pc;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            retire <= '0;
        end else begin
            retire <= nextRec;
        end
    end

endmodule

`default_nettype wire

// File: hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  rv_pkg::decodeBundle exBundle,
    input  rv_pkg::retireRec    retire,
    input  logic                branchTaken,
    output logic                fwdA,
    output logic                fwdB,
    output logic                flush
);

    logic retireWrites;

    // Only a real register write may be forwarded
    assign retireWrites = retire.valid && retire.regWrite && (retire.rd != 5'd0);

    assign fwdA = retireWrites && (retire.rd == exBundle.rs1);
    assign fwdB = retireWrites && (retire.rd == exBundle.rs2);

    // Squash the instruction behind a taken branch or jump
    assign flush = exBundle.valid && branchTaken;

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module regFile (
    input  logic                clk,
    input  logic                rstN,
    input  logic [4:0]          raddr1,
    input  logic [4:0]          raddr2,
    input  logic                we,
    input  logic [4:0]          waddr,
    input  logic [`RV_XLEN-1:0] wdata,
    output logic [`RV_XLEN-1:0] rdata1,
    output logic [`RV_XLEN-1:0] rdata2
);

    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:`RV_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int idx = 1; idx < `RV_REG_COUNT; idx++) begin
                regs[idx] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Reads see a write only after the clock edge
    always_comb begin
        rdata1 = '0;
        rdata2 = '0;
        if (raddr1 != 5'd0) begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 != 5'd0) begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

`default_nettype wire

// File: rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Datapath width
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_REG_COUNT 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: rv_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

    // Register-register view of an instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFormat;

    // Immediate view of the same word
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFormat;

    typedef union packed {
        rFormat r;
        iFormat i;
    } instrWord;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluPassB
    } aluOp;

    typedef struct packed {
        logic       regWrite;
        aluOp       aluOp;
        logic       aluSrcImm;
        logic       branch;
        logic [2:0] branchCond;
        logic       jump;
        logic       jalr;
        logic       linkResult;
        logic       isLui;
    } ctrlBundle;

    typedef struct packed {
        logic                valid;
        ctrlBundle           ctrl;
        logic [`RV_XLEN-1:0] rd1;
        logic [`RV_XLEN-1:0] rd2;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] pcPlus4;
        logic [`RV_XLEN-1:0] immExt;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
    } decodeBundle;

    typedef struct packed {
        logic                valid;
        logic                regWrite;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
        logic [`RV_XLEN-1:0] pc;
    } retireRec;

endpackage

`default_nettype wire
